/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;     // Data word or raw instruction
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [4:0]  reg_idx_t;  // Register file index

    typedef enum logic [2:0] {
        ALU_ADD,  // ADDU ADDIU LW SW
        ALU_SUB,  // SUBU
        ALU_AND,
        ALU_OR,
        ALU_SLT,  // Signed compare
        ALU_ORU   // ORI, upper half of B ignored
    } alu_op_t;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pc_src_t;
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam addr_t    RESET_PC = 32'h0000_0000;  // First fetch
    localparam addr_t    PC_STEP  = 32'd4;
    localparam reg_idx_t REG_ZERO = 5'd0;

    // Operand mux shared by decode and execute forwarding
    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;  // ALU result in memory stage
            FWD_WB:  return wb_val;   // Value being written back
            default: return reg_val;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/fetch_stage.sv */
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  logic    stall,
    input  pc_src_t pc_src,
    input  addr_t   branch_target,
    input  addr_t   jump_target,
    output addr_t   fetch_address,
    input  word_t   instruction,
    output word_t   id_instruction,
    output addr_t   id_pc_plus4
);

    addr_t pc;        // Address being fetched
    addr_t pc_plus4;  // Sequential successor
    addr_t next_pc;   // Chosen by decode

    assign fetch_address = pc;
    assign pc_plus4      = pc + PC_STEP;

    always_comb begin
        case (pc_src)
            PC_BRANCH: next_pc = branch_target;  // Taken BEQ/BNE
            PC_JUMP:   next_pc = jump_target;    // J
            default:   next_pc = pc_plus4;
        endcase
    end

    // PC and IF/ID hold together on a stall
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc             <= RESET_PC;
            id_instruction <= '0;  // All-zero word decodes as a no-op
            id_pc_plus4    <= '0;
        end else if (!stall) begin
            pc             <= next_pc;
            id_instruction <= instruction;  // Delay slot enters here when a branch is taken
            id_pc_plus4    <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* src/control_unit.sv */
`default_nettype none

module control_unit import cpu_pkg::*; (
    input  word_t   instruction,
    input  logic    operands_equal,
    output pc_src_t pc_src,
    output alu_op_t alu_op,
    output logic    alu_src,
    output logic    reg_dst,
    output logic    sign_extend,
    output logic    mem_read,
    output logic    mem_write,
    output logic    mem_to_reg,
    output logic    reg_write,
    output logic    uses_rs,
    output logic    uses_rt,
    output logic    is_branch
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];

    always_comb begin
        pc_src      = PC_SEQ;  // Defaults form a no-op
        alu_op      = ALU_ADD;
        alu_src     = 1'b0;
        reg_dst     = 1'b0;
        sign_extend = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        reg_write   = 1'b0;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        is_branch   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                reg_dst = 1'b1;  // Result goes to rd
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: begin
                        reg_write = 1'b0;  // Unknown funct, nothing written
                        uses_rs   = 1'b0;
                        uses_rt   = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_LW, OP_SW: begin
                alu_src     = 1'b1;  // Base plus signed offset
                sign_extend = 1'b1;
                uses_rs     = 1'b1;
                mem_read    = (opcode == OP_LW);
                mem_to_reg  = (opcode == OP_LW);
                mem_write   = (opcode == OP_SW);
                uses_rt     = (opcode == OP_SW);  // Store data
                reg_write   = (opcode != OP_SW);
            end
            OP_ORI: begin
                alu_op    = ALU_ORU;  // Zero-extended immediate
                alu_src   = 1'b1;
                uses_rs   = 1'b1;
                reg_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                is_branch = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                if (operands_equal == (opcode == OP_BEQ)) pc_src = PC_BRANCH;
            end
            OP_J:    pc_src = PC_JUMP;
            default: ;  // Unknown opcode is a no-op
        endcase
    end

endmodule

`default_nettype wire

/* src/register_file.sv */
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t read_rs,
    input  reg_idx_t read_rt,
    output word_t    rs_data,
    output word_t    rt_data,
    input  reg_idx_t write_idx,
    input  word_t    write_data,
    input  logic     write_en
);

    word_t regs [1:31];  // No storage for register zero

    // Zero reads as zero, a same-cycle write passes straight through
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == REG_ZERO) return '0;
        if (write_en && write_idx == idx) return write_data;
        return regs[idx];
    endfunction

    always_comb begin
        rs_data = read_port(read_rs);
        rt_data = read_port(read_rt);
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_idx != REG_ZERO) begin
            regs[write_idx] <= write_data;  // Writeback at end of WB cycle
        end
    end

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t id_rs,
    input  reg_idx_t id_rt,
    input  logic     id_uses_rs,
    input  logic     id_uses_rt,
    input  logic     id_is_branch,
    input  reg_idx_t ex_rs,
    input  reg_idx_t ex_rt,
    input  reg_idx_t ex_dst,
    input  logic     ex_reg_write,
    input  logic     ex_mem_read,
    input  reg_idx_t mem_dst,
    input  logic     mem_reg_write,
    input  logic     mem_mem_read,
    input  reg_idx_t wb_dst,
    input  logic     wb_reg_write,
    output fwd_sel_t id_fwd_rs,
    output fwd_sel_t id_fwd_rt,
    output fwd_sel_t ex_fwd_rs,
    output fwd_sel_t ex_fwd_rt,
    output logic     stall
);

    logic mem_ok;  // Memory stage holds a forwardable ALU result
    logic wb_ok;   // Writeback stage writes a real register
    logic ex_hit;  // Decode reads what execute will write
    logic mem_hit; // Decode reads what memory stage will write

    assign mem_ok = mem_reg_write && !mem_mem_read && (mem_dst != REG_ZERO);
    assign wb_ok  = wb_reg_write && (wb_dst != REG_ZERO);

    // Memory stage is younger so it wins over writeback
    assign id_fwd_rs = (mem_ok && mem_dst == id_rs) ? FWD_MEM :
                       (wb_ok && wb_dst == id_rs)   ? FWD_WB  : FWD_REG;
    assign id_fwd_rt = (mem_ok && mem_dst == id_rt) ? FWD_MEM :
                       (wb_ok && wb_dst == id_rt)   ? FWD_WB  : FWD_REG;
    assign ex_fwd_rs = (mem_ok && mem_dst == ex_rs) ? FWD_MEM :
                       (wb_ok && wb_dst == ex_rs)   ? FWD_WB  : FWD_REG;
    assign ex_fwd_rt = (mem_ok && mem_dst == ex_rt) ? FWD_MEM :
                       (wb_ok && wb_dst == ex_rt)   ? FWD_WB  : FWD_REG;

    assign ex_hit  = (ex_dst != REG_ZERO) &&
                     ((id_uses_rs && ex_dst == id_rs) || (id_uses_rt && ex_dst == id_rt));
    assign mem_hit = (mem_dst != REG_ZERO) &&
                     ((id_uses_rs && mem_dst == id_rs) || (id_uses_rt && mem_dst == id_rt));

    assign stall = (ex_mem_read && ex_hit)                     // Load-use
                 | (id_is_branch && ex_reg_write && ex_hit)    // Branch on result still in ALU
                 | (id_is_branch && mem_mem_read && mem_hit);  // Branch on load in memory

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     stall,
    input  word_t    id_instruction,
    input  addr_t    id_pc_plus4,
    input  alu_op_t  alu_op,
    input  logic     alu_src,
    input  logic     reg_dst,
    input  logic     sign_extend,
    input  logic     mem_read,
    input  logic     mem_write,
    input  logic     mem_to_reg,
    input  logic     reg_write,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  fwd_sel_t id_fwd_rs,
    input  fwd_sel_t id_fwd_rt,
    input  word_t    mem_alu_result,
    input  word_t    wb_value,
    output logic     operands_equal,
    output addr_t    branch_target,
    output addr_t    jump_target,
    output reg_idx_t ex_rs,
    output reg_idx_t ex_rt,
    output reg_idx_t ex_dst,
    output word_t    ex_rs_data,
    output word_t    ex_rt_data,
    output word_t    ex_imm,
    output alu_op_t  ex_alu_op,
    output logic     ex_alu_src,
    output logic     ex_mem_read,
    output logic     ex_mem_write,
    output logic     ex_mem_to_reg,
    output logic     ex_reg_write
);

    word_t      rs_val;  // Forwarded operands
    word_t      rt_val;
    logic [15:0] imm16;
    word_t      imm_ext;

    assign rs_val = fwd_mux(id_fwd_rs, rs_data, mem_alu_result, wb_value);
    assign rt_val = fwd_mux(id_fwd_rt, rt_data, mem_alu_result, wb_value);
    assign operands_equal = (rs_val == rt_val);  // Early branch compare

    assign imm16   = id_instruction[15:0];
    assign imm_ext = sign_extend ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
    // Branch offset is always signed words from the delay slot address
    assign branch_target = id_pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jump_target   = {id_pc_plus4[31:28], id_instruction[25:0], 2'b00};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_alu_op     <= ALU_ADD;
            ex_alu_src    <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_reg_write  <= 1'b0;
        end else begin
            ex_alu_op     <= alu_op;
            ex_alu_src    <= alu_src;
            ex_mem_read   <= mem_read & ~stall;  // Stall injects a bubble
            ex_mem_write  <= mem_write & ~stall;
            ex_mem_to_reg <= mem_to_reg;
            ex_reg_write  <= reg_write & ~stall;
        end
    end

    always_ff @(posedge clock) begin
        ex_rs      <= id_instruction[25:21];
        ex_rt      <= id_instruction[20:16];
        ex_dst     <= reg_dst ? id_instruction[15:11] : id_instruction[20:16];  // rd or rt
        ex_rs_data <= rs_val;
        ex_rt_data <= rt_val;
        ex_imm     <= imm_ext;
    end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t ex_dst,
    input  word_t    ex_rs_data,
    input  word_t    ex_rt_data,
    input  word_t    ex_imm,
    input  alu_op_t  ex_alu_op,
    input  logic     ex_alu_src,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  logic     ex_mem_to_reg,
    input  logic     ex_reg_write,
    input  fwd_sel_t ex_fwd_rs,
    input  fwd_sel_t ex_fwd_rt,
    input  word_t    wb_value,
    output word_t    mem_alu_result,
    output word_t    mem_store_data,
    output reg_idx_t mem_dst,
    output logic     mem_mem_read,
    output logic     mem_mem_write,
    output logic     mem_mem_to_reg,
    output logic     mem_reg_write
);

    word_t op_a;        // Forwarded rs
    word_t rt_val;      // Forwarded rt, also store data
    word_t op_b;        // After immediate select
    word_t alu_result;

    // EX/MEM result feeds back for memory-stage forwarding
    assign op_a   = fwd_mux(ex_fwd_rs, ex_rs_data, mem_alu_result, wb_value);
    assign rt_val = fwd_mux(ex_fwd_rt, ex_rt_data, mem_alu_result, wb_value);
    assign op_b   = ex_alu_src ? ex_imm : rt_val;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_ORU: alu_result = op_a | {16'h0000, op_b[15:0]};
            default: alu_result = op_a + op_b;  // Also address generation
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mem_mem_read   <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
            mem_reg_write  <= 1'b0;
        end else begin
            mem_mem_read   <= ex_mem_read;
            mem_mem_write  <= ex_mem_write;
            mem_mem_to_reg <= ex_mem_to_reg;
            mem_reg_write  <= ex_reg_write;
        end
    end

    always_ff @(posedge clock) begin
        mem_alu_result <= alu_result;
        mem_store_data <= rt_val;
        mem_dst        <= ex_dst;
    end

endmodule

`default_nettype wire

/* src/memory_writeback.sv */
`default_nettype none

module memory_writeback import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  word_t    mem_alu_result,
    input  word_t    mem_store_data,
    input  reg_idx_t mem_dst,
    input  logic     mem_mem_read,
    input  logic     mem_mem_write,
    input  logic     mem_mem_to_reg,
    input  logic     mem_reg_write,
    output addr_t    memory_address,
    output logic     memory_read,
    output logic     memory_write,
    output word_t    memory_write_data,
    input  word_t    memory_read_data,
    output reg_idx_t wb_dst,
    output word_t    wb_value,
    output logic     wb_reg_write
);

    logic  wb_mem_to_reg;
    word_t wb_alu_result;
    word_t wb_load_data;

    // Single-cycle data access straight from EX/MEM
    assign memory_address    = mem_alu_result;
    assign memory_read       = mem_mem_read;
    assign memory_write      = mem_mem_write;
    assign memory_write_data = mem_store_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else begin
            wb_reg_write  <= mem_reg_write;
            wb_mem_to_reg <= mem_mem_to_reg;
        end
    end

    always_ff @(posedge clock) begin
        wb_dst        <= mem_dst;
        wb_alu_result <= mem_alu_result;
        wb_load_data  <= memory_read_data;  // Load word captured here
    end

    assign wb_value = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

`default_nettype wire

/* src/processor.sv */
`default_nettype none

module processor import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    output addr_t fetch_address,
    input  word_t instruction,
    output addr_t memory_address,
    output logic  memory_read,
    output logic  memory_write,
    output word_t memory_write_data,
    input  word_t memory_read_data
);

    // IF/ID and next-PC
    word_t    id_instruction;
    addr_t    id_pc_plus4;
    addr_t    branch_target;
    addr_t    jump_target;
    pc_src_t  pc_src;
    logic     stall;

    // Decode control
    alu_op_t  alu_op;
    logic     alu_src, reg_dst, sign_extend, mem_read, mem_write, mem_to_reg;
    logic     reg_write, uses_rs, uses_rt, is_branch, operands_equal;
    word_t    rs_data, rt_data;
    fwd_sel_t id_fwd_rs, id_fwd_rt, ex_fwd_rs, ex_fwd_rt;

    // ID/EX
    reg_idx_t ex_rs, ex_rt, ex_dst;
    word_t    ex_rs_data, ex_rt_data, ex_imm;
    alu_op_t  ex_alu_op;
    logic     ex_alu_src, ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_reg_write;

    // EX/MEM and MEM/WB
    word_t    mem_alu_result, mem_store_data;
    reg_idx_t mem_dst, wb_dst;
    logic     mem_mem_read, mem_mem_write, mem_mem_to_reg, mem_reg_write;
    word_t    wb_value;
    logic     wb_reg_write;

    fetch_stage fetch_stage_inst (.*);

    control_unit control_unit_inst (.*, .instruction(id_instruction));

    register_file register_file_inst (
        .*,
        .read_rs    (id_instruction[25:21]),
        .read_rt    (id_instruction[20:16]),
        .write_idx  (wb_dst),
        .write_data (wb_value),
        .write_en   (wb_reg_write)
    );

    hazard_unit hazard_unit_inst (
        .*,
        .id_rs        (id_instruction[25:21]),
        .id_rt        (id_instruction[20:16]),
        .id_uses_rs   (uses_rs),
        .id_uses_rt   (uses_rt),
        .id_is_branch (is_branch)
    );

    decode_stage decode_stage_inst (.*);

    execute_stage execute_stage_inst (.*);

    memory_writeback memory_writeback_inst (.*);

endmodule

`default_nettype wire

/* dv/tb_memory.sv */
`default_nettype none

module tb_memory import cpu_pkg::*; #(
    parameter addr_t LOAD_ADDR = 32'h0000_0200,  // Word read by the load-use test
    parameter word_t LOAD_WORD = 32'h1234_5670
) (
    input  logic  clock,
    input  addr_t fetch_address,
    output word_t instruction,
    input  addr_t memory_address,
    input  logic  memory_write,
    input  word_t memory_write_data,
    output word_t memory_read_data
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t rom [0:63];   // 256-byte program space
    word_t ram [0:255];  // 1 KB data space

    function automatic word_t r_type(input logic [5:0] fn, input reg_idx_t rd,
                                     input reg_idx_t rs, input reg_idx_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};  // shamt unused
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_idx_t rt,
                                     input reg_idx_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input logic [25:0] word_target);
        return {OP_J, word_target};
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;  // All-zero word is a no-op
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] = 32'hda7a_0000 | (i << 2);  // Low half is the byte address
        end
        ram[LOAD_ADDR[9:2]] = LOAD_WORD;

        // ALU chain, each result used by the next instruction
        rom[0]  = i_type(OP_ADDIU, 5'd1, 5'd0, 16'd5);       // r1 = 5
        rom[1]  = i_type(OP_ADDIU, 5'd2, 5'd1, 16'd7);       // r2 = 12
        rom[2]  = r_type(FN_SUBU, 5'd3, 5'd2, 5'd1);         // r3 = 7
        rom[3]  = r_type(FN_AND, 5'd4, 5'd3, 5'd2);          // r4 = 4
        rom[4]  = r_type(FN_OR, 5'd5, 5'd4, 5'd3);           // r5 = 7
        rom[5]  = r_type(FN_SLT, 5'd6, 5'd1, 5'd5);          // r6 = 1
        rom[6]  = i_type(OP_ORI, 5'd7, 5'd6, 16'hf0f0);      // r7 = 0xf0f1
        rom[7]  = r_type(FN_SUBU, 5'd8, 5'd1, 5'd2);         // r8 = -7
        rom[8]  = r_type(FN_SLT, 5'd9, 5'd8, 5'd1);          // r9 = 1, signed compare
        rom[9]  = i_type(OP_SW, 5'd7, 5'd0, 16'h0100);
        rom[10] = i_type(OP_SW, 5'd9, 5'd0, 16'h0104);
        rom[11] = i_type(OP_SW, 5'd8, 5'd0, 16'h0108);
        rom[12] = i_type(OP_SW, 5'd5, 5'd0, 16'h010c);
        // Load then immediate use
        rom[13] = i_type(OP_LW, 5'd10, 5'd0, LOAD_ADDR[15:0]);
        rom[14] = r_type(FN_ADDU, 5'd11, 5'd10, 5'd1);       // r11 = load + 5
        rom[15] = i_type(OP_SW, 5'd11, 5'd0, 16'h0110);
        // Branches with delay slots
        rom[16] = r_type(FN_ADDU, 5'd12, 5'd1, 5'd0);        // r12 = 5
        rom[17] = i_type(OP_BEQ, 5'd1, 5'd12, 16'd2);        // Taken, to rom[20]
        rom[18] = i_type(OP_SW, 5'd12, 5'd0, 16'h0114);      // Delay slot
        rom[19] = i_type(OP_SW, 5'd1, 5'd0, 16'h0118);       // Skipped
        rom[20] = i_type(OP_SW, 5'd2, 5'd0, 16'h011c);
        rom[21] = i_type(OP_BNE, 5'd1, 5'd1, 16'd5);         // Never taken
        rom[22] = i_type(OP_SW, 5'd3, 5'd0, 16'h0120);       // Delay slot
        rom[23] = i_type(OP_SW, 5'd4, 5'd0, 16'h0124);
        // Jump and register zero
        rom[24] = j_type(26'd27);
        rom[25] = i_type(OP_SW, 5'd5, 5'd0, 16'h0128);       // Delay slot
        rom[26] = i_type(OP_SW, 5'd6, 5'd0, 16'h012c);       // Skipped
        rom[27] = i_type(OP_ADDIU, 5'd0, 5'd0, 16'd99);      // r0 stays zero
        rom[28] = i_type(OP_SW, 5'd0, 5'd0, 16'h0130);
        rom[29] = i_type(OP_ORI, 5'd13, 5'd0, 16'hbeef);
        rom[30] = i_type(OP_SW, 5'd13, 5'd0, 16'h01fc);      // End marker
        rom[31] = j_type(26'd31);                            // Park, rom[32] is the slot
    end

    assign instruction      = rom[fetch_address[7:2]];
    assign memory_read_data = ram[memory_address[9:2]];

    always @(posedge clock) begin
        if (memory_write) begin
            ram[memory_address[9:2]] = memory_write_data;  // Never a load in the same cycle
        end
    end

endmodule

`default_nettype wire

/* dv/processor_tb.sv */
`default_nettype none

module processor_tb import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NUM_TESTS = 6;
    localparam int    TIMEOUT   = 500;             // Cycles per wait
    localparam addr_t LOAD_ADDR = 32'h0000_0200;
    localparam word_t LOAD_WORD = 32'h1234_5670;

    logic  clock = 1'b0;
    logic  rst_n = 1'b0;
    addr_t fetch_address;
    word_t instruction;
    addr_t memory_address;
    logic  memory_read;
    logic  memory_write;
    word_t memory_write_data;
    word_t memory_read_data;

    string test_names [NUM_TESTS] = '{"reset_state", "alu_forwarding", "load_use",
                                      "branch_delay_slot", "jump_and_zero", "store_order"};
    int    test_last [NUM_TESTS]  = '{0, 4, 5, 9, 11, 12};  // Stores seen when test is done
    int    test_errors [NUM_TESTS];
    int    tests_run;
    int    store_count;

    addr_t exp_addr [$];  // Expected stores in program order
    word_t exp_data [$];
    int    exp_test [$];  // Owning test of each store

    always #2 clock = ~clock;

    processor processor_inst (.*);

    tb_memory #(.LOAD_ADDR(LOAD_ADDR), .LOAD_WORD(LOAD_WORD)) tb_memory_inst (.*);

    task automatic expect_store(input int t, input addr_t addr, input word_t data);
        exp_test.push_back(t);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_expected();
        expect_store(1, 32'h100, 32'h0000_f0f1);       // slt(5, 7) | 0xf0f0
        expect_store(1, 32'h104, 32'd1);               // -7 < 5 signed
        expect_store(1, 32'h108, 32'hffff_fff9);       // 5 - 12
        expect_store(1, 32'h10c, 32'd7);               // (7 & 12) | 7
        expect_store(2, 32'h110, LOAD_WORD + 32'd5);
        expect_store(3, 32'h114, 32'd5);               // BEQ slot
        expect_store(3, 32'h11c, 32'd12);              // BEQ target with 0x118 skipped
        expect_store(3, 32'h120, 32'd7);               // BNE slot
        expect_store(3, 32'h124, 32'd4);               // Fall through
        expect_store(4, 32'h128, 32'd7);               // J slot with 0x12c skipped
        expect_store(4, 32'h130, 32'd0);               // r0 after a write to it
        expect_store(5, 32'h1fc, 32'h0000_beef);       // Marker
    endtask

    task automatic check_idle(input string when);
        assert (!memory_write && !memory_read) else begin
            test_errors[0]++;
            $display("FAIL reset_state: write/read %s expected 0/0 actual %b/%b",
                     when, memory_write, memory_read);
        end
        assert (fetch_address == RESET_PC) else begin
            test_errors[0]++;
            $display("FAIL reset_state: fetch_address %s expected %h actual %h",
                     when, RESET_PC, fetch_address);
        end
    endtask

    // Called once per memory_write cycle
    task automatic check_store(input addr_t addr, input word_t data);
        int t;
        assert (store_count < exp_addr.size()) else begin
            test_errors[NUM_TESTS - 1]++;
            $display("store_order: unexpected extra store of %h to %h", data, addr);
        end
        if (store_count < exp_addr.size()) begin
            t = exp_test[store_count];
            assert (addr == exp_addr[store_count]) else begin
                test_errors[t]++;
                $display("FAIL %s: store %0d address expected %h actual %h",
                         test_names[t], store_count, exp_addr[store_count], addr);
            end
            assert (data == exp_data[store_count]) else begin
                test_errors[t]++;
                $display("FAIL %s: store %0d data expected %h actual %h",
                         test_names[t], store_count, exp_data[store_count], data);
            end
        end
        store_count++;
    endtask

    task automatic wait_for_stores(input int count, output bit done);
        int cycles;
        cycles = 0;
        while (store_count < count && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        done = (store_count >= count);
    endtask

    task automatic report_test(input int t);
        if (test_errors[t] == 0) begin
            $display("test %-18s ok", test_names[t]);
        end else begin
            $display("test %-18s %0d errors", test_names[t], test_errors[t]);
        end
        tests_run++;
    endtask

    reset_quiet: assert property (@(posedge clock) !rst_n |-> (!memory_write && !memory_read))
        else begin
            test_errors[0]++;
            $display("FAIL reset_state: write/read in reset expected 0/0 actual %b/%b",
                     $sampled(memory_write), $sampled(memory_read));
        end

    always @(posedge clock) begin
        if (rst_n && memory_write) begin
            check_store(memory_address, memory_write_data);
        end
    end

    initial begin
        bit done;
        int total_errors;
        int failed_tests;
        done         = 1'b1;
        total_errors = 0;
        failed_tests = 0;
        tests_run    = 0;
        store_count  = 0;
        build_expected();
        for (int i = 0; i < 10; i++) begin
            @(negedge clock);
            check_idle("during reset");
        end
        rst_n = 1'b1;  // Released on a falling edge
        #1;
        check_idle("after reset");
        report_test(0);
        for (int t = 1; t < NUM_TESTS && done; t++) begin
            wait_for_stores(test_last[t], done);
            if (!done) begin
                $display("program did not finish: %0d of %0d stores seen within %0d cycles",
                         store_count, test_last[t], TIMEOUT);
            end else begin
                if (t == NUM_TESTS - 1) begin
                    repeat (20) @(negedge clock);  // Window for stray stores after the marker
                    assert (store_count == exp_addr.size()) else begin
                        test_errors[t]++;
                        $display("FAIL store_order: store count expected %0d actual %0d",
                                 exp_addr.size(), store_count);
                    end
                end
                report_test(t);
            end
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_errors += test_errors[t];
            if (test_errors[t] != 0) failed_tests++;
        end
        $display("%0d of %0d tests run, %0d with errors, %0d failed checks",
                 tests_run, NUM_TESTS, failed_tests, total_errors);
        if (done && total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/cpu_pkg.sv
src/fetch_stage.sv
src/control_unit.sv
src/register_file.sv
src/hazard_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_writeback.sv
src/processor.sv
dv/tb_memory.sv
dv/processor_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module processor_tb -f compile.f -o processor_sim
./obj_dir/processor_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
